/* hdl/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// architectural word width
`define MIPS_DATA_WIDTH 32

// register index width and count
`define MIPS_REG_ADDR_WIDTH 5
`define MIPS_REG_COUNT 32

// fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* hdl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAndi  = 6'h0c,
        opLui   = 6'h0f,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // r-type function codes
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // operation class handed from main decoder to alu decoder
    typedef enum logic [1:0] {
        aluClassAdd    = 2'b00,
        aluClassSub    = 2'b01,
        aluClassFunct  = 2'b10,
        aluClassImmAnd = 2'b11
    } aluOpClassT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluSll = 3'd5
    } aluOperationT;

endpackage

`default_nettype wire

/* hdl/cpuCtrlIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface cpuCtrlIf import mipsPkg::*; ();
    logic regDst;
    logic jump;
    logic jumpAndLink;
    logic jumpRegister;
    logic branch;
    logic branchNe;
    logic memRead;
    logic memToReg;
    logic memWrite;
    logic aluSrc;
    logic regWrite;
    logic shiftLeftLogical;
    logic loadUpperImmediate;
    aluOpClassT aluOpClass;

    modport decoder (
        output regDst, jump, jumpAndLink, jumpRegister, branch, branchNe,
        output memRead, memToReg, memWrite, aluSrc, regWrite,
        output shiftLeftLogical, loadUpperImmediate, aluOpClass
    );

    // muxes and write enables in the core
    modport datapath (
        input regDst, jumpAndLink, memToReg, memWrite, aluSrc, regWrite,
        input shiftLeftLogical, loadUpperImmediate, aluOpClass
    );

    modport flow (input jump, jumpAndLink, jumpRegister, branch, branchNe);

    modport aluCtl (input aluOpClass);
endinterface

`default_nettype wire

/* hdl/opcodeControl.sv */
`timescale 1ns/100ps
`default_nettype none

module opcodeControl import mipsPkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    cpuCtrlIf.decoder  ctrl
);

    logic isRType;
    logic isJ;
    logic isJal;
    logic isJr;
    logic isBeq;
    logic isBne;
    logic isAddi;
    logic isAndi;
    logic isLw;
    logic isSw;
    logic isSll;
    logic isLui;

    // one flag per instruction and all low for an unknown opcode
    always_comb begin
        isRType = 1'b0;
        isJ     = 1'b0;
        isJal   = 1'b0;
        isBeq   = 1'b0;
        isBne   = 1'b0;
        isAddi  = 1'b0;
        isAndi  = 1'b0;
        isLw    = 1'b0;
        isSw    = 1'b0;
        isLui   = 1'b0;
        case (opcodeT'(opcode))
            opRType: isRType = 1'b1;
            opJ:     isJ     = 1'b1;
            opJal:   isJal   = 1'b1;
            opBeq:   isBeq   = 1'b1;
            opBne:   isBne   = 1'b1;
            opAddi:  isAddi  = 1'b1;
            opAndi:  isAndi  = 1'b1;
            opLw:    isLw    = 1'b1;
            opSw:    isSw    = 1'b1;
            opLui:   isLui   = 1'b1;
            default: ;
        endcase
    end

    // funct only matters under the r-type opcode
    assign isJr  = isRType && (funct == fnJr);
    assign isSll = isRType && (funct == fnSll);

    assign ctrl.regDst             = isRType;
    assign ctrl.jump               = isJ || isJal;
    assign ctrl.jumpAndLink        = isJal;
    assign ctrl.jumpRegister       = isJr;
    assign ctrl.branch             = isBeq;
    assign ctrl.branchNe           = isBne;
    assign ctrl.memRead            = isLw;
    assign ctrl.memToReg           = isLw;
    assign ctrl.memWrite           = isSw;
    assign ctrl.aluSrc             = isLw || isSw || isAddi || isAndi;
    assign ctrl.shiftLeftLogical   = isSll;
    assign ctrl.loadUpperImmediate = isLui;

    // jr is the only r-type without a destination
    assign ctrl.regWrite = (isRType && !isJr) || isJal || isAddi || isAndi || isLw || isLui;

    always_comb begin
        if (isRType) begin
            ctrl.aluOpClass = aluClassFunct;
        end else if (isBeq || isBne) begin
            ctrl.aluOpClass = aluClassSub;
        end else if (isAndi) begin
            ctrl.aluOpClass = aluClassImmAnd;
        end else begin
            ctrl.aluOpClass = aluClassAdd;
        end
    end

endmodule

`default_nettype wire

/* hdl/aluControl.sv */
`timescale 1ns/100ps
`default_nettype none

module aluControl import mipsPkg::*; (
    cpuCtrlIf.aluCtl     ctrl,
    input  logic [5:0]   funct,
    output aluOperationT aluOperation
);

    always_comb begin
        case (ctrl.aluOpClass)
            aluClassSub:    aluOperation = aluSub;
            aluClassImmAnd: aluOperation = aluAnd;
            aluClassFunct: begin
                case (functT'(funct))
                    fnAdd:   aluOperation = aluAdd;
                    fnSub:   aluOperation = aluSub;
                    fnAnd:   aluOperation = aluAnd;
                    fnOr:    aluOperation = aluOr;
                    fnSlt:   aluOperation = aluSlt;
                    fnSll:   aluOperation = aluSll;
                    // jr and anything unsupported
                    default: aluOperation = aluAdd;
                endcase
            end
            default:        aluOperation = aluAdd;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module alu import mipsPkg::*; (
    input  aluOperationT                aluOperation,
    input  logic [`MIPS_DATA_WIDTH-1:0] operandA,
    input  logic [`MIPS_DATA_WIDTH-1:0] operandB,
    input  logic [4:0]                  shamt,
    output logic [`MIPS_DATA_WIDTH-1:0] result,
    output logic                        zero
);

    always_comb begin
        case (aluOperation)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            // signed compare, result is 0 or 1
            aluSlt:  result = {{(`MIPS_DATA_WIDTH-1){1'b0}},
                               $signed(operandA) < $signed(operandB)};
            aluSll:  result = operandB << shamt;
            default: result = '0;
        endcase
    end

    // branch compare relies on this
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module registerFile (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] readAddrB,
    output logic [`MIPS_DATA_WIDTH-1:0]     readDataA,
    output logic [`MIPS_DATA_WIDTH-1:0]     readDataB,
    input  logic                            writeEn,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     writeData
);

    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // plain array reads, a same-cycle write shows up next cycle
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // $zero survives reset and every attempted write
    zeroRegister: assert property (@(posedge clk) disable iff (rst)
        (readAddrA == '0) |-> (readDataA == '0));

endmodule

`default_nettype wire

/* hdl/programCounter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module programCounter (
    input  logic                        clk,
    input  logic                        rst,
    cpuCtrlIf.flow                      ctrl,
    input  logic                        zero,
    input  logic [25:0]                 jumpTarget,
    input  logic [`MIPS_DATA_WIDTH-1:0] branchOffset,
    input  logic [`MIPS_DATA_WIDTH-1:0] registerTarget,
    output logic [`MIPS_DATA_WIDTH-1:0] pc,
    output logic [`MIPS_DATA_WIDTH-1:0] pcPlus4
);

    logic                        branchTaken;
    logic [`MIPS_DATA_WIDTH-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // beq on equal, bne on not equal
    assign branchTaken = (ctrl.branch && zero) || (ctrl.branchNe && !zero);

    always_comb begin
        if (ctrl.jumpRegister) begin
            nextPc = registerTarget;
        end else if (ctrl.jump || ctrl.jumpAndLink) begin
            // region of pc+4 with the word index from the instruction
            nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
        end else if (branchTaken) begin
            nextPc = pcPlus4 + {branchOffset[29:0], 2'b00};
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // a jr through a register could break alignment
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module mipsCore import mipsPkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    output logic [`MIPS_DATA_WIDTH-1:0] imemAddr,
    input  logic [`MIPS_DATA_WIDTH-1:0] imemData,
    output logic [`MIPS_DATA_WIDTH-1:0] dmemAddr,
    output logic [`MIPS_DATA_WIDTH-1:0] dmemWdata,
    output logic                        dmemWe,
    input  logic [`MIPS_DATA_WIDTH-1:0] dmemRdata
);

    logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] writeAddr;
    logic [15:0]                     imm;
    logic [4:0]                      shamt;
    logic [`MIPS_DATA_WIDTH-1:0]     immExt;
    logic [`MIPS_DATA_WIDTH-1:0]     readDataA;
    logic [`MIPS_DATA_WIDTH-1:0]     readDataB;
    logic [`MIPS_DATA_WIDTH-1:0]     operandB;
    logic [`MIPS_DATA_WIDTH-1:0]     aluResult;
    logic [`MIPS_DATA_WIDTH-1:0]     writeData;
    logic [`MIPS_DATA_WIDTH-1:0]     pc;
    logic [`MIPS_DATA_WIDTH-1:0]     pcPlus4;
    logic                            zero;
    logic                            regWriteEn;
    aluOperationT                    aluOperation;

    cpuCtrlIf ctrl ();

    assign rs    = imemData[25:21];
    assign rt    = imemData[20:16];
    assign rd    = imemData[15:11];
    assign imm   = imemData[15:0];
    assign shamt = ctrl.shiftLeftLogical ? imemData[10:6] : 5'd0;

    // andi zero-extends, everything else sign-extends
    assign immExt = (ctrl.aluOpClass == aluClassImmAnd) ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign operandB = ctrl.aluSrc ? immExt : readDataB;

    assign writeAddr = ctrl.jumpAndLink ? 5'd31 : (ctrl.regDst ? rd : rt);

    always_comb begin
        if (ctrl.jumpAndLink) begin
            writeData = pcPlus4;
        end else if (ctrl.loadUpperImmediate) begin
            writeData = {imm, 16'b0};
        end else if (ctrl.memToReg) begin
            writeData = dmemRdata;
        end else begin
            writeData = aluResult;
        end
    end

    // no side effects while in reset
    assign regWriteEn = ctrl.regWrite && !rst;
    assign dmemWe     = ctrl.memWrite && !rst;

    assign imemAddr  = pc;
    assign dmemAddr  = aluResult;
    assign dmemWdata = readDataB;

    opcodeControl opcodeControlInst (
        .opcode (imemData[31:26]),
        .funct  (imemData[5:0]),
        .ctrl   (ctrl.decoder)
    );

    aluControl aluControlInst (
        .ctrl         (ctrl.aluCtl),
        .funct        (imemData[5:0]),
        .aluOperation (aluOperation)
    );

    alu aluInst (
        .aluOperation (aluOperation),
        .operandA     (readDataA),
        .operandB     (operandB),
        .shamt        (shamt),
        .result       (aluResult),
        .zero         (zero)
    );

    registerFile registerFileInst (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (rs),
        .readAddrB (rt),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (regWriteEn),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    programCounter programCounterInst (
        .clk            (clk),
        .rst            (rst),
        .ctrl           (ctrl.flow),
        .zero           (zero),
        .jumpTarget     (imemData[25:0]),
        .branchOffset   (immExt),
        .registerTarget (readDataA),
        .pc             (pc),
        .pcPlus4        (pcPlus4)
    );

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset seen high by the first ten rising edges
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/mipsCore_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module mipsCore_tb;

    localparam int memWords = 256;

    logic                        clk;
    logic                        rst;
    logic [`MIPS_DATA_WIDTH-1:0] imemAddr;
    // a store word until the first edge so that reset must gate dmemWe
    logic [`MIPS_DATA_WIDTH-1:0] imemData = 32'hAC00_0000;
    logic [`MIPS_DATA_WIDTH-1:0] dmemAddr;
    logic [`MIPS_DATA_WIDTH-1:0] dmemWdata;
    logic                        dmemWe;
    logic [`MIPS_DATA_WIDTH-1:0] dmemRdata;

    // golden image holds three header words, the program and then address and data pairs
    logic [`MIPS_DATA_WIDTH-1:0] golden [memWords];
    logic [`MIPS_DATA_WIDTH-1:0] imem [memWords];
    logic [`MIPS_DATA_WIDTH-1:0] dmem [memWords];
    logic [`MIPS_DATA_WIDTH-1:0] finalAddr;
    logic [`MIPS_DATA_WIDTH-1:0] prevAddr = '1;

    int progLen;
    int storeCount;
    int storeBase;
    int timeoutLimit;
    int storeIdx = 0;
    int cycleCount = 0;
    bit failed = 1'b0;

    clockGen clockGenInst (
        .clk (clk),
        .rst (rst)
    );

    mipsCore mipsCore_inst (
        .clk       (clk),
        .rst       (rst),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemWe    (dmemWe),
        .dmemRdata (dmemRdata)
    );

    function automatic int wordIndex(input logic [`MIPS_DATA_WIDTH-1:0] addr);
        return int'(addr[9:2]);
    endfunction

    task automatic abortRun(input string reason);
        failed = 1'b1;
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkStore(
        input logic [`MIPS_DATA_WIDTH-1:0] gotAddr,
        input logic [`MIPS_DATA_WIDTH-1:0] gotData,
        input logic [`MIPS_DATA_WIDTH-1:0] expectedAddr,
        input logic [`MIPS_DATA_WIDTH-1:0] expectedData,
        input int                          index
    );
        if ((gotAddr !== expectedAddr) || (gotData !== expectedData)) begin
            abortRun($sformatf("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                $time, index, gotData, gotAddr, expectedData, expectedAddr));
        end
    endtask

    task automatic checkAddress(
        input logic [`MIPS_DATA_WIDTH-1:0] got,
        input logic [`MIPS_DATA_WIDTH-1:0] expected,
        input string                       what
    );
        if (got !== expected) begin
            abortRun($sformatf("FAILED at %0t: %s is %h, expected %h",
                $time, what, got, expected));
        end
    endtask

    initial begin
        int i;
        for (i = 0; i < memWords; i++) begin
            imem[i] = '0;
        end
        $readmemh("tb/program_golden.txt", golden);
        if ($isunknown(golden[0]) || $isunknown(golden[1]) || $isunknown(golden[2])) begin
            abortRun("golden file could not be read or has no header words");
        end else begin
            progLen      = int'(golden[0]);
            storeCount   = int'(golden[1]);
            finalAddr    = golden[2];
            storeBase    = 3 + progLen;
            timeoutLimit = 4 * progLen + 50;
            for (i = 0; i < progLen; i++) begin
                imem[i] = golden[3 + i];
            end
        end
    end

    // fetch register loaded from the address the core moves to at this edge
    always @(posedge clk) begin
        if (rst) begin
            imemData <= imem[wordIndex(`MIPS_RESET_PC)];
        end else begin
            imemData <= imem[wordIndex(mipsCore_inst.programCounterInst.nextPc)];
        end
    end

    // data memory with a combinational read
    assign dmemRdata = dmem[wordIndex(dmemAddr)];

    always @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < memWords; j++) begin
                dmem[j] <= '0;
            end
        end else if (dmemWe) begin
            dmem[wordIndex(dmemAddr)] <= dmemWdata;
        end
    end

    always @(posedge clk) begin
        logic stuck;
        if (rst) begin
            if (dmemWe !== 1'b0) begin
                abortRun("dmemWe was not held low during reset");
            end
        end else begin
            if (cycleCount == 0) begin
                checkAddress(imemAddr, `MIPS_RESET_PC, "first fetch address after reset");
            end
            cycleCount++;
            if (dmemWe === 1'b1) begin
                if (storeIdx >= storeCount) begin
                    abortRun($sformatf("unexpected extra store of %h to address %h at time %0t",
                        dmemWdata, dmemAddr, $time));
                end else begin
                    checkStore(dmemAddr, dmemWdata, golden[storeBase + 2 * storeIdx],
                        golden[storeBase + 2 * storeIdx + 1], storeIdx);
                    storeIdx++;
                end
            end else if (dmemWe !== 1'b0) begin
                abortRun("dmemWe is unknown after reset");
            end
            // a self-loop shows as the same fetch address twice in a row
            stuck    = (imemAddr === prevAddr);
            prevAddr = imemAddr;
            if (stuck) begin
                checkAddress(imemAddr, finalAddr, "self-loop address");
                if (!failed && (storeIdx == storeCount)) begin
                    $display("** PASS **");
                    $finish;
                end else if (!failed) begin
                    abortRun($sformatf("program stopped after %0d of %0d expected stores",
                        storeIdx, storeCount));
                end
            end else if (cycleCount >= timeoutLimit) begin
                abortRun($sformatf("program never reached its final address %h in %0d cycles",
                    finalAddr, timeoutLimit));
            end
        end
    end

endmodule

`default_nettype wire

/* tb/program_golden.txt */
// header: program length in words, number of expected stores, final self-loop address
// then program words four per line, then expected stores as address and data in order
00000029 0000000E 00000094
// program, trailing number is the byte address of the first word on the line
20010005 2002FFFD 00221820 00222022 // 00
00222824 00223025 0041382A 3048F0F0 // 10
00014900 3C0A1234 AC030000 AC040004 // 20
AC050008 AC06000C AC070010 AC080014 // 30
AC090018 AC0A001C AC010040 8C0B0040 // 40
216B0064 AC0B0044 102B0001 200C0001 // 50
10210001 AC0C0048 14210001 218C0001 // 60
142B0001 AC000048 AC0C0048 08000021 // 70
AC0C004C 0C000026 AC1F0050 20000007 // 80
AC000054 08000025 200D0003 AC0D0058 // 90
03E00008                            // a0
// expected stores
00000000 00000002
00000004 00000008
00000008 00000005
0000000C FFFFFFFD
00000010 00000001
00000014 0000F0F0
00000018 00000050
0000001C 12340000
00000040 00000005
00000044 00000069
00000048 00000002
00000058 00000003
00000050 00000088
00000054 00000000

/* compile.f */
+incdir+hdl
hdl/mipsPkg.sv
hdl/cpuCtrlIf.sv
hdl/opcodeControl.sv
hdl/aluControl.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/programCounter.sv
hdl/mipsCore.sv
tb/clockGen.sv
tb/mipsCore_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mipsPkg.sv
      - hdl/cpuCtrlIf.sv
      - hdl/opcodeControl.sv
      - hdl/aluControl.sv
      - hdl/alu.sv
      - hdl/registerFile.sv
      - hdl/programCounter.sv
      - hdl/mipsCore.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/clockGen.sv
      - tb/mipsCore_tb.sv
